// ==== Bender.yml ====
package:
  name: core_cluster

sources:
  - design/cluster_pkg.sv
  - design/mem_port_if.sv
  - design/task_scheduler.sv
  - design/mini_core.sv
  - design/mem_arbiter.sv
  - design/result_mem.sv
  - design/core_cluster_top.sv
  - target: test
    files:
      - verif/tb_core_cluster.sv

// ==== design/cluster_pkg.sv ====
package cluster_pkg;

	localparam int INSN_W         = 32;
	localparam int INSN_BUS_W     = 8;
	localparam int INSN_LOAD_TIME = INSN_W / INSN_BUS_W;
	localparam int TM_WORD_W      = 36;

	typedef enum logic [1:0] {
		FENCE_NO,
		FENCE_ACQ,
		FENCE_REL
	} fence_t;

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_XOR,
		OP_MOV
	} op_t;

	typedef struct packed {
		op_t         op;
		logic [5:0]  addr;      // Result address base
		logic [15:0] imm;
		logic [7:0]  rsvd;
	} insn_t;

	// Overlays a full task word
	typedef struct packed {
		logic [3:0]  frame_num; // Instruction frames that follow
		fence_t      fence;
		logic        stop;
		logic [4:0]  stop_addr;
		logic [3:0]  core_mask;
		logic [3:0]  init_mask;
		logic [15:0] init_r0;
	} ctrl_frame_t;

endpackage

// ==== design/core_cluster_top.sv ====
`timescale 1ns/100ps

module core_cluster_top #(
	parameter int NUM_CORES = 4,
	parameter int DATA_W    = 16,
	parameter int TM_DEPTH  = 32,
	parameter int RES_DEPTH = 64
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              tm_we,
	input  logic [$clog2(TM_DEPTH)-1:0]       tm_addr,
	input  logic [cluster_pkg::TM_WORD_W-1:0] tm_wdata,
	input  logic                              run,
	input  logic [$clog2(RES_DEPTH)-1:0]      rd_addr,
	output logic [DATA_W-1:0]                 rd_data,
	output logic                              done
);
	import cluster_pkg::*;

	localparam int RES_AW = $clog2(RES_DEPTH);

	logic [NUM_CORES-1:0]              start;
	logic [NUM_CORES-1:0]              ready;
	logic [NUM_CORES-1:0]              insn_load_vect;
	logic [NUM_CORES-1:0]              init_r0_vect;
	logic [INSN_BUS_W-1:0]             insn_data;
	logic [$clog2(INSN_LOAD_TIME)-1:0] insn_load_cnt;
	logic [DATA_W-1:0]                 init_r0;

	mem_port_if #(.DATA_W(DATA_W), .ADDR_W(RES_AW)) core_port [NUM_CORES] ();
	mem_port_if #(.DATA_W(DATA_W), .ADDR_W(RES_AW)) mem_port ();

	task_scheduler #(
		.NUM_CORES(NUM_CORES),
		.DATA_W   (DATA_W),
		.TM_DEPTH (TM_DEPTH)
	) u_sched (
		.clk           (clk),
		.reset         (reset),
		.tm_we         (tm_we),
		.tm_addr       (tm_addr),
		.tm_wdata      (tm_wdata),
		.run           (run),
		.ready         (ready),
		.start         (start),
		.insn_data     (insn_data),
		.insn_load_cnt (insn_load_cnt),
		.insn_load_vect(insn_load_vect),
		.init_r0_vect  (init_r0_vect),
		.init_r0       (init_r0),
		.done          (done)
	);

	for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
		mini_core #(.DATA_W(DATA_W), .CORE_ID(i)) u_core (
			.clk          (clk),
			.reset        (reset),
			.start_pulse  (start[i]),
			.insn_data    (insn_data),
			.insn_load_cnt(insn_load_cnt),
			.load_en      (insn_load_vect[i]),
			.init_en      (init_r0_vect[i]),
			.init_r0      (init_r0),
			.ready        (ready[i]),
			.mem          (core_port[i])
		);
	end

	mem_arbiter #(.NUM_CORES(NUM_CORES)) u_arb (
		.clk       (clk),
		.reset     (reset),
		.core_ports(core_port),
		.mem       (mem_port)
	);

	result_mem #(.DATA_W(DATA_W), .RES_DEPTH(RES_DEPTH)) u_res (
		.clk    (clk),
		.reset  (reset),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.wr     (mem_port)
	);

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter #(
	parameter int NUM_CORES = 4
) (
	input  logic          clk,
	input  logic          reset,
	mem_port_if.memory    core_ports [NUM_CORES],
	mem_port_if.requester mem
);

	localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
	localparam int AW    = $bits(mem.addr);
	localparam int DW    = $bits(mem.wdata);

	logic [NUM_CORES-1:0] req_v;
	logic [AW-1:0]        addr_v [NUM_CORES];
	logic [DW-1:0]        wdata_v [NUM_CORES];
	logic [NUM_CORES-1:0] grant;
	logic [IDX_W-1:0]     gnt_idx;
	logic [IDX_W-1:0]     ptr;
	logic [IDX_W-1:0]     pick_idx;
	logic                 pick_valid;

	for (genvar i = 0; i < NUM_CORES; i++) begin : g_port
		assign req_v[i]          = core_ports[i].req;
		assign addr_v[i]         = core_ports[i].addr;
		assign wdata_v[i]        = core_ports[i].wdata;
		assign core_ports[i].ack = grant[i] & mem.ack; // Winner only
	end

	// First requester at or after ptr
	always_comb begin
		int unsigned idx;
		pick_valid = 1'b0;
		pick_idx   = '0;
		for (int k = NUM_CORES - 1; k >= 0; k--) begin
			idx = (int'(ptr) + k) % NUM_CORES;
			if (req_v[idx]) begin
				pick_valid = 1'b1;
				pick_idx   = IDX_W'(idx);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			grant   <= '0;
			gnt_idx <= '0;
			ptr     <= '0;
		end else if (grant == '0) begin
			if (pick_valid) begin
				grant   <= NUM_CORES'(1) << pick_idx;
				gnt_idx <= pick_idx;
			end
		end else if (!req_v[gnt_idx] && !mem.ack) begin
			grant <= '0; // Four-phase cycle closed
			ptr   <= (gnt_idx == IDX_W'(NUM_CORES - 1)) ? '0 : gnt_idx + 1'b1;
		end
	end

	assign mem.req   = (|grant) & req_v[gnt_idx];
	assign mem.addr  = addr_v[gnt_idx];
	assign mem.wdata = wdata_v[gnt_idx];

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant));

endmodule

// ==== design/mem_port_if.sv ====
`timescale 1ns/100ps

interface mem_port_if #(
	parameter int DATA_W = 16,
	parameter int ADDR_W = 6
);

	logic              req;
	logic              ack;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;

	modport requester (
		output req,
		output addr,
		output wdata,
		input  ack
	);

	modport memory (
		input  req,
		input  addr,
		input  wdata,
		output ack
	);

endinterface

// ==== design/mini_core.sv ====
`timescale 1ns/100ps

module mini_core #(
	parameter int DATA_W  = 16,
	parameter int CORE_ID = 0
) (
	input  logic                                            clk,
	input  logic                                            reset,
	input  logic                                            start_pulse,
	input  logic [cluster_pkg::INSN_BUS_W-1:0]              insn_data,
	input  logic [$clog2(cluster_pkg::INSN_LOAD_TIME)-1:0]  insn_load_cnt,
	input  logic                                            load_en,
	input  logic                                            init_en,
	input  logic [DATA_W-1:0]                               init_r0,
	output logic                                            ready,
	mem_port_if.requester                                   mem
);
	import cluster_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_EXEC, S_WAIT_ACK, S_WAIT_DROP} state_t;

	state_t            state;
	insn_t             insn;
	logic [DATA_W-1:0] r0;
	logic [DATA_W-1:0] imm;
	logic [DATA_W-1:0] result;

	assign imm   = DATA_W'(insn.imm);
	assign ready = (state == S_IDLE);

	always_comb begin
		case (insn.op)
			OP_ADD:  result = r0 + imm;
			OP_SUB:  result = r0 - imm;
			OP_XOR:  result = r0 ^ imm;
			default: result = imm; // OP_MOV
		endcase
	end

	always_ff @(posedge clk) begin
		if (load_en)
			insn[insn_load_cnt * INSN_BUS_W +: INSN_BUS_W] <= insn_data;
		if (init_en)
			r0 <= init_r0;
		else if (state == S_EXEC)
			r0 <= result; // Write back
		if (state == S_EXEC) begin
			mem.addr  <= insn.addr + 6'(CORE_ID);
			mem.wdata <= result;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= S_IDLE;
			mem.req <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start_pulse)
						state <= S_EXEC;
				end
				S_EXEC: begin
					mem.req <= 1'b1; // Addr and data settle with req
					state   <= S_WAIT_ACK;
				end
				S_WAIT_ACK: begin
					if (mem.ack) begin
						mem.req <= 1'b0;
						state   <= S_WAIT_DROP;
					end
				end
				default: begin
					if (!mem.ack)
						state <= S_IDLE;
				end
			endcase
		end
	end

	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		$fell(mem.req) |-> $past(mem.ack));

endmodule

// ==== design/result_mem.sv ====
`timescale 1ns/100ps

module result_mem #(
	parameter int DATA_W    = 16,
	parameter int RES_DEPTH = 64
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [$clog2(RES_DEPTH)-1:0] rd_addr,
	output logic [DATA_W-1:0]            rd_data,
	mem_port_if.memory                   wr
);

	logic [DATA_W-1:0] mem [RES_DEPTH];
	logic              ack_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
			for (int i = 0; i < RES_DEPTH; i++)
				mem[i] <= '0;
		end else begin
			ack_q <= wr.req; // Ack follows req by one cycle
			if (wr.req && !ack_q)
				mem[wr.addr] <= wr.wdata;
		end
	end

	assign wr.ack  = ack_q;
	assign rd_data = mem[rd_addr];

endmodule

// ==== design/task_scheduler.sv ====
`timescale 1ns/100ps

module task_scheduler #(
	parameter int NUM_CORES = 4,
	parameter int DATA_W    = 16,
	parameter int TM_DEPTH  = 32
) (
	input  logic                                            clk,
	input  logic                                            reset,
	input  logic                                            tm_we,
	input  logic [$clog2(TM_DEPTH)-1:0]                     tm_addr,
	input  logic [cluster_pkg::TM_WORD_W-1:0]               tm_wdata,
	input  logic                                            run,
	input  logic [NUM_CORES-1:0]                            ready,
	output logic [NUM_CORES-1:0]                            start,
	output logic [cluster_pkg::INSN_BUS_W-1:0]              insn_data,
	output logic [$clog2(cluster_pkg::INSN_LOAD_TIME)-1:0]  insn_load_cnt,
	output logic [NUM_CORES-1:0]                            insn_load_vect,
	output logic [NUM_CORES-1:0]                            init_r0_vect,
	output logic [DATA_W-1:0]                               init_r0,
	output logic                                            done
);
	import cluster_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_CTRL, S_LOAD, S_HALT} state_t;

	localparam int TP_W  = $clog2(TM_DEPTH);
	localparam int CNT_W = $clog2(INSN_LOAD_TIME);

	logic [TM_WORD_W-1:0] tm [TM_DEPTH];
	logic [TM_WORD_W-1:0] cur_word;
	ctrl_frame_t          cf;
	state_t               state;
	logic [TP_W-1:0]      tp;
	logic [3:0]           frames_left;
	fence_t               fence_r;
	logic [NUM_CORES-1:0] core_mask_r;
	logic                 stop_r;
	logic [TP_W-1:0]      stop_addr_r;
	logic [CNT_W-1:0]     cnt;
	logic [NUM_CORES-1:0] cf_core_mask;
	logic [NUM_CORES-1:0] cf_need;
	logic                 settled;
	logic                 ctrl_ok;
	logic                 ctrl_accept;
	logic                 halt_frame;
	logic                 act_ready;
	logic                 load_go;
	logic                 last_part;

	always_ff @(posedge clk) begin
		if (tm_we)
			tm[tm_addr] <= tm_wdata;
	end

	assign cur_word     = tm[tp];
	assign cf           = ctrl_frame_t'(cur_word);
	assign cf_core_mask = NUM_CORES'(cf.core_mask);
	assign halt_frame   = cf.stop && (cf.frame_num == '0);

	// Cores only drop ready the cycle after start
	assign settled = (start == '0);

	// Init targets must be idle too, else a running core loses its R0
	assign cf_need = (fence_r == FENCE_ACQ || cf.fence == FENCE_REL) ? '1 :
		cf_core_mask | NUM_CORES'(cf.init_mask);
	assign ctrl_ok     = settled && ((ready & cf_need) == cf_need);
	assign ctrl_accept = (state == S_CTRL) && !halt_frame && ctrl_ok;

	assign act_ready = settled && ((ready & core_mask_r) == core_mask_r);
	assign load_go   = (state == S_LOAD) && (cnt != '0 || act_ready);
	assign last_part = (cnt == CNT_W'(INSN_LOAD_TIME - 1));

	assign insn_load_cnt  = cnt;
	assign insn_load_vect = load_go ? core_mask_r : '0;
	assign insn_data      = cur_word[cnt * INSN_BUS_W +: INSN_BUS_W];

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= S_IDLE;
			tp           <= '0;
			frames_left  <= '0;
			fence_r      <= FENCE_NO;
			core_mask_r  <= '0;
			stop_r       <= 1'b0;
			stop_addr_r  <= '0;
			cnt          <= '0;
			start        <= '0;
			init_r0_vect <= '0;
			done         <= 1'b0;
		end else begin
			start        <= '0; // One-cycle pulses
			init_r0_vect <= '0;
			case (state)
				S_IDLE: begin
					if (run)
						state <= S_CTRL;
				end
				S_CTRL: begin
					if (halt_frame) begin
						if (settled && (&ready)) begin
							done  <= 1'b1;
							state <= S_HALT;
						end
					end else if (ctrl_ok) begin
						init_r0_vect <= NUM_CORES'(cf.init_mask);
						fence_r      <= cf.fence;
						core_mask_r  <= cf_core_mask;
						stop_r       <= cf.stop;
						stop_addr_r  <= TP_W'(cf.stop_addr);
						frames_left  <= cf.frame_num;
						tp           <= tp + 1'b1;
						if (cf.frame_num != '0)
							state <= S_LOAD;
					end
				end
				S_LOAD: begin
					if (load_go) begin
						cnt <= cnt + 1'b1;
						if (last_part) begin
							cnt         <= '0;
							start       <= core_mask_r;
							frames_left <= frames_left - 1'b1;
							if (frames_left == 4'd1) begin
								tp    <= stop_r ? stop_addr_r : tp + 1'b1; // Stop jump
								state <= S_CTRL;
							end else begin
								tp <= tp + 1'b1;
							end
						end
					end
				end
				default: ; // Halted until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_accept)
			init_r0 <= DATA_W'(cf.init_r0);
	end

	// Start only reaches cores that report idle
	a_start_ready: assert property (@(posedge clk) disable iff (reset)
		(start & ~ready) == '0);

	// Parts after the first follow on back-to-back cycles
	a_cnt_range: assert property (@(posedge clk) disable iff (reset)
		(insn_load_vect != '0 && !last_part) |=>
			(insn_load_vect != '0 && insn_load_cnt == $past(insn_load_cnt) + 1'b1));

endmodule

// ==== verif/golden_tasks.txt ====
# T <task addr> <task word>, both hex
# E <test name> <result addr> <expected value>, hex
# single_add
T 00 100110005
T 01 000000700
# broadcast
T 02 000011000
T 03 000022000
T 04 000043000
T 05 100F84000
T 06 09000FF00
# chain
T 07 200620100
T 08 020002300
T 09 060000500
# fence_acq
T 0A 140880050
T 0B 028000500
T 0C 100100000
T 0D 0EBBEEF00
# stop_jump
T 0E 132440007
T 0F 030000200
T 10 10011DEAD
T 11 0FCDEAD00
T 12 020000000
E single_add 00 000C
E broadcast 10 10FF
E broadcast 11 20FF
E broadcast 12 30FF
E broadcast 13 40FF
E chain 20 0000
E chain 21 011E
E chain 22 311D
E fence_acq 2B BEEF
E stop_jump 32 0009
E stop_jump 3C 0000

// ==== verif/tb_core_cluster.sv ====
`timescale 1ns/100ps

module tb_core_cluster;
	import cluster_pkg::*;

	localparam int NUM_CORES = 4;
	localparam int DATA_W    = 16;
	localparam int TM_DEPTH  = 32;
	localparam int RES_DEPTH = 64;
	localparam int TM_AW     = $clog2(TM_DEPTH);
	localparam int RES_AW    = $clog2(RES_DEPTH);

	logic                 clk;
	logic                 reset;
	logic                 tm_we;
	logic [TM_AW-1:0]     tm_addr;
	logic [TM_WORD_W-1:0] tm_wdata;
	logic                 run;
	logic [RES_AW-1:0]    rd_addr;
	logic [DATA_W-1:0]    rd_data;
	logic                 done;

	int                   t_addr [$];
	logic [TM_WORD_W-1:0] t_word [$];
	string                e_name [$];
	int                   e_addr [$];
	logic [DATA_W-1:0]    e_value [$];
	bit                   loaded;

	core_cluster_top #(
		.NUM_CORES(NUM_CORES),
		.DATA_W   (DATA_W),
		.TM_DEPTH (TM_DEPTH),
		.RES_DEPTH(RES_DEPTH)
	) dut (
		.clk     (clk),
		.reset   (reset),
		.tm_we   (tm_we),
		.tm_addr (tm_addr),
		.tm_wdata(tm_wdata),
		.run     (run),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.done    (done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED %s: expected 0x%04h, actual 0x%04h",
				name, expected, actual));
	endtask

	task automatic read_golden();
		int                   fd;
		int                   n;
		int                   ch;
		int                   addr;
		string                tag;
		string                name;
		logic [TM_WORD_W-1:0] word;
		logic [DATA_W-1:0]    value;
		fd = $fopen("verif/golden_tasks.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open verif/golden_tasks.txt");
		end else begin
			while ($fscanf(fd, "%s", tag) == 1) begin
				if (tag == "T") begin
					n = $fscanf(fd, "%h %h", addr, word);
					if (n != 2) begin
						abort_run("Malformed task line in the golden file");
					end else begin
						t_addr.push_back(addr);
						t_word.push_back(word);
					end
				end else if (tag == "E") begin
					n = $fscanf(fd, "%s %h %h", name, addr, value);
					if (n != 3) begin
						abort_run("Malformed expect line in the golden file");
					end else begin
						e_name.push_back(name);
						e_addr.push_back(addr);
						e_value.push_back(value);
					end
				end else begin
					do
						ch = $fgetc(fd); // Skip comment text
					while (ch != "\n" && ch != -1);
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		reset    = 1'b1;
		tm_we    = 1'b0;
		tm_addr  = '0;
		tm_wdata = '0;
		run      = 1'b0;
		rd_addr  = '0;
		read_golden();
		loaded = 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		foreach (t_addr[i]) begin
			@(posedge clk);
			tm_we    <= 1'b1;
			tm_addr  <= TM_AW'(t_addr[i]);
			tm_wdata <= t_word[i];
		end
		@(negedge clk);
		check_value("done_idle", '0, DATA_W'(done)); // Low until the program halts
		@(posedge clk);
		tm_we <= 1'b0;
		run   <= 1'b1;
		do
			@(negedge clk);
		while (!done);
		foreach (e_addr[i]) begin
			@(posedge clk);
			rd_addr <= RES_AW'(e_addr[i]);
			@(negedge clk); // Combinational read has settled
			check_value(e_name[i], e_value[i], rd_data);
		end
		check_value("done_held", DATA_W'(1), DATA_W'(done));
		if (e_addr.size() == 0) begin
			abort_run("The golden file holds no expected values");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

	// Budget scales with program length
	initial begin
		wait (loaded);
		repeat (200 * t_addr.size() + 1000) @(posedge clk);
		abort_run("Timeout: done never rose within the cycle budget");
	end

endmodule

// ==== vlog.f ====
design/cluster_pkg.sv
design/mem_port_if.sv
design/task_scheduler.sv
design/mini_core.sv
design/mem_arbiter.sv
design/result_mem.sv
design/core_cluster_top.sv
verif/tb_core_cluster.sv
